// ==== Makefile ====
# Verilator build and run of the UART testbench

VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = uartTb
FILELIST  = src.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) uart_consts.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== src.f ====
+incdir+.
uartBusPkg.sv
uartLinePkg.sv
uartRegIf.sv
uartFifo.sv
uartTx.sv
uartRx.sv
uartCore.sv
uartBusBridge.sv
uartTop.sv
uartTb_sva.sv
uartTb.sv

// ==== uartBusBridge.sv ====
// UART bus bridge
`timescale 1ns/100ps
`include "uart_consts.svh"

module uartBusBridge (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  logic                 HSELUART,
  input  logic                 HWRITE,
  input  uartBusPkg::busAddr_t HADDR,
  input  uartBusPkg::busWord_t HWDATA,
  output uartBusPkg::busWord_t HREADUART,
  uartRegIf.bridge             regs
);

  // Number of byte lanes in a bus word and the address bits that pick one
  localparam int laneCount = `UART_XLEN / 8;
  localparam int laneBits = $clog2(laneCount);

  logic [laneBits-1:0] laneSel;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // The address phase is captured here so the data phase sees stable strobes
  // A read and a write never overlap because HWRITE picks one of them
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      regs.rd <= 1'b0;
      regs.wr <= 1'b0;
      regs.addr <= '0;
    end else begin
      regs.rd <= HSELUART & ~HWRITE;
      regs.wr <= HSELUART & HWRITE;
      regs.addr <= HADDR;
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  // The low address bits name the lane that carries the byte
  assign laneSel = regs.addr[laneBits-1:0];

  // Write data arrives in the lane of its byte address
  assign regs.wdata = HWDATA[8 * laneSel +: 8];

  // Read data goes out on every lane, so any lane the master looks at is right
  assign HREADUART = {laneCount{regs.rdata}};

endmodule

// ==== uartBusPkg.sv ====
// UART bus-side types
`include "uart_consts.svh"

package uartBusPkg;

  // Byte address of a register inside the UART window
  typedef logic [2:0] busAddr_t;

  // One word on the system bus
  // The UART replicates its byte over every lane of this word
  typedef logic [`UART_XLEN-1:0] busWord_t;

endpackage

// ==== uartCore.sv ====
// UART register core
`timescale 1ns/100ps

module uartCore (
  input  logic     HCLK,
  input  logic     rstN,
  uartRegIf.core   regs,
  input  logic     SIN,
  output logic     SOUT,
  output logic     INTR,
  output logic     TXRDYb,
  output logic     RXRDYb
);
  import uartBusPkg::*;
  import uartLinePkg::*;

  // Register byte addresses
  localparam busAddr_t addrData = 3'd0;
  localparam busAddr_t addrIer = 3'd1;
  localparam busAddr_t addrIir = 3'd2;
  localparam busAddr_t addrLcr = 3'd3;
  localparam busAddr_t addrLsr = 3'd5;
  localparam busAddr_t addrScr = 3'd7;

  divisor_t divisor;
  divisor_t divCount;
  logic [1:0] ier;
  uartByte_t lcr;
  uartByte_t scr;
  uartByte_t txData;
  uartByte_t rxData;
  uartByte_t rxByte;
  uartByte_t lsr;
  uartByte_t iir;
  logic dlab;
  logic tick;
  logic txPush;
  logic txTake;
  logic txFull;
  logic txEmpty;
  logic txIdle;
  logic rxPop;
  logic rxValid;
  logic rxFrameError;
  logic rxFull;
  logic rxEmpty;
  logic lsrRead;
  logic overrun;
  logic frameErr;
  logic rxInt;
  logic txInt;

  // Divisor latch access bit swaps addresses 0 and 1 over to the divisor
  assign dlab = lcr[7];

  // THR writes and RBR reads only touch the FIFOs while DLAB is clear
  assign txPush = regs.wr && (regs.addr == addrData) && !dlab;
  assign rxPop = regs.rd && (regs.addr == addrData) && !dlab && !rxEmpty;
  assign lsrRead = regs.rd && (regs.addr == addrLsr);

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      divisor <= divisor_t'(1);
      ier <= '0;
      lcr <= '0;
      scr <= '0;
    end else if (regs.wr) begin
      case (regs.addr)
        addrData: if (dlab) divisor[7:0] <= regs.wdata;
        addrIer: begin
          if (dlab) divisor[15:8] <= regs.wdata;
          else ier <= regs.wdata[1:0];
        end
        addrLcr: lcr <= regs.wdata;
        addrScr: scr <= regs.wdata;
        default: ;
      endcase
    end
  end

  // Sticky line errors, cleared by an LSR read unless a new one lands in that cycle
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      overrun <= 1'b0;
      frameErr <= 1'b0;
    end else begin
      if (lsrRead) begin
        overrun <= 1'b0;
        frameErr <= 1'b0;
      end
      // A byte that finds the FIFO full with no pop in flight is lost
      if (rxValid && rxFull && !rxPop) overrun <= 1'b1;
      if (rxValid && rxFrameError) frameErr <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Baud tick
  ////////////////////////////////////////

  // One tick every divisor cycles; a zero divisor behaves like 1
  assign tick = (divCount + divisor_t'(1)) >= divisor;

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) divCount <= '0;
    else divCount <= tick ? '0 : divCount + 1'b1;
  end

  ////////////////////////////////////////
  // Status and read data
  ////////////////////////////////////////

  // TEMT needs the shifter idle as well as an empty FIFO
  assign lsr = {1'b0, txEmpty & txIdle, txEmpty, 1'b0, frameErr, 1'b0, overrun, !rxEmpty};

  // Receive data outranks transmit empty in IIR
  assign rxInt = ier[0] && !rxEmpty;
  assign txInt = ier[1] && txEmpty;
  assign iir = rxInt ? 8'h04 : (txInt ? 8'h02 : 8'h01);
  assign INTR = rxInt | txInt;

  // 16550-style DMA ready pins, active low
  assign TXRDYb = txFull;
  assign RXRDYb = rxEmpty;

  always_comb begin
    case (regs.addr)
      addrData: regs.rdata = dlab ? divisor[7:0] : rxData;
      addrIer: regs.rdata = dlab ? divisor[15:8] : {6'b0, ier};
      addrIir: regs.rdata = iir;
      addrLcr: regs.rdata = lcr;
      addrLsr: regs.rdata = lsr;
      addrScr: regs.rdata = scr;
      default: regs.rdata = '0;
    endcase
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Transmit FIFO drops a THR write when full
  uartFifo i_txFifo (.HCLK, .rstN, .push(txPush), .pushData(regs.wdata), .pop(txTake),
                     .popData(txData), .full(txFull), .empty(txEmpty), .level());

  uartFifo i_rxFifo (.HCLK, .rstN, .push(rxValid), .pushData(rxByte), .pop(rxPop),
                     .popData(rxData), .full(rxFull), .empty(rxEmpty), .level());

  uartTx i_uartTx (.HCLK, .rstN, .tick, .dataValid(!txEmpty), .data(txData),
                   .take(txTake), .idle(txIdle), .SOUT);

  uartRx i_uartRx (.HCLK, .rstN, .tick, .SIN, .valid(rxValid), .data(rxByte),
                   .frameError(rxFrameError));

endmodule

// ==== uartFifo.sv ====
// UART byte FIFO
`timescale 1ns/100ps
`include "uart_consts.svh"

module uartFifo #(
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  logic                     HCLK,
  input  logic                     rstN,
  input  logic                     push,
  input  uartLinePkg::uartByte_t   pushData,
  input  logic                     pop,
  output uartLinePkg::uartByte_t   popData,
  output logic                     full,
  output logic                     empty,
  output uartLinePkg::fifoLevel_t  level
);
  import uartLinePkg::*;

  localparam int ptrBits = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  uartByte_t mem [DEPTH];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic doPush;
  logic doPop;

  assign empty = (level == '0);
  assign full = (level == fifoLevel_t'(DEPTH));

  // A pop frees the slot a push into a full FIFO needs in the same cycle
  assign doPop = pop && !empty;
  assign doPush = push && (!full || doPop);

  // Head of the queue is visible without a pop, as RBR needs
  assign popData = mem[rdPtr];

  always_ff @(posedge HCLK) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      level <= '0;
    end else begin
      // Pointers wrap by compare so a depth that is not a power of two works
      if (doPush) wrPtr <= (wrPtr == ptrBits'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == ptrBits'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop) level <= level + 1'b1;
      else if (doPop && !doPush) level <= level - 1'b1;
    end
  end

endmodule

// ==== uartLinePkg.sv ====
// UART serial-line types
`include "uart_consts.svh"

package uartLinePkg;

  // Data byte on the line, also the width of every register
  typedef logic [7:0] uartByte_t;

  // Baud divisor made of the DLM and DLL bytes
  typedef logic [15:0] divisor_t;

  // Position of the current baud tick inside one serial bit
  typedef logic [3:0] tickCount_t;

  // Index of the data bit being shifted, LSB first
  typedef logic [2:0] bitIndex_t;

  // FIFO occupancy, one wider than needed for the pointers so a full FIFO fits
  typedef logic [$clog2(`UART_FIFO_DEPTH + 1)-1:0] fifoLevel_t;

  // Frame phases of the serializer and the deserializer
  typedef enum logic [1:0] {stTxIdle, stTxStart, stTxData, stTxStop} txState_e;
  typedef enum logic [1:0] {stRxIdle, stRxStart, stRxData, stRxStop} rxState_e;

endpackage

// ==== uartRegIf.sv ====
// UART register access interface
`timescale 1ns/100ps

interface uartRegIf;
  import uartBusPkg::*;
  import uartLinePkg::*;

  // One-cycle strobes of the data phase
  logic rd;
  logic wr;

  // Registered byte address of the access
  busAddr_t addr;

  // Byte taken from the selected lane of the write data
  uartByte_t wdata;

  // Register contents at addr, valid in the same cycle
  uartByte_t rdata;

  // The bridge turns bus transfers into register strobes
  modport bridge (output rd, wr, addr, wdata, input rdata);

  // The core decodes the strobes and answers with read data
  modport core (input rd, wr, addr, wdata, output rdata);

endinterface

// ==== uartRx.sv ====
// UART 8N1 receiver
`timescale 1ns/100ps
`include "uart_consts.svh"

module uartRx (
  input  logic                   HCLK,
  input  logic                   rstN,
  input  logic                   tick,
  input  logic                   SIN,
  output logic                   valid,
  output uartLinePkg::uartByte_t data,
  output logic                   frameError
);
  import uartLinePkg::*;

  // Start bit is checked half a bit in, every later bit a full bit after that
  localparam tickCount_t midTick = tickCount_t'(`UART_OVERSAMPLE / 2 - 1);
  localparam tickCount_t lastTick = tickCount_t'(`UART_OVERSAMPLE - 1);

  rxState_e state;
  tickCount_t tickCnt;
  bitIndex_t bitIdx;
  uartByte_t shiftReg;
  logic sinMeta;
  logic sinSync;
  logic sinLast;
  logic atMid;
  logic atEnd;

  // SIN is asynchronous to HCLK, two flops before anything looks at it
  // They reset high to match an idle line
  // The third flop keeps the previous level so a high-to-low change can be seen
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      sinMeta <= 1'b1;
      sinSync <= 1'b1;
      sinLast <= 1'b1;
    end else begin
      sinMeta <= SIN;
      sinSync <= sinMeta;
      sinLast <= sinSync;
    end
  end

  assign atMid = tick && (tickCnt == midTick);
  assign atEnd = tick && (tickCnt == lastTick);

  // The byte is handed over at the middle of the stop bit
  // A low stop bit is reported but the byte is still delivered
  assign valid = (state == stRxStop) && atEnd;
  assign frameError = valid && !sinSync;
  assign data = shiftReg;

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      state <= stRxIdle;
      tickCnt <= '0;
      bitIdx <= '0;
    end else if (state == stRxIdle) begin
      tickCnt <= '0;
      // Falling edge of the line may be a start bit
      // A line still low after a bad stop bit does not start a new frame
      if (sinLast && !sinSync) state <= stRxStart;
    end else if (tick) begin
      case (state)
        stRxStart: begin
          if (atMid) begin
            tickCnt <= '0;
            bitIdx <= '0;
            // A line back high by mid-bit was only a glitch
            state <= sinSync ? stRxIdle : stRxData;
          end else begin
            tickCnt <= tickCnt + 1'b1;
          end
        end
        stRxData: begin
          if (atEnd) begin
            tickCnt <= '0;
            if (bitIdx == '1) state <= stRxStop;
            bitIdx <= bitIdx + 1'b1;
          end else begin
            tickCnt <= tickCnt + 1'b1;
          end
        end
        default: begin
          if (atEnd) state <= stRxIdle;
          else tickCnt <= tickCnt + 1'b1;
        end
      endcase
    end
  end

  // Bits arrive LSB first, so each one enters at the top
  always_ff @(posedge HCLK) begin
    if ((state == stRxData) && atEnd) shiftReg <= {sinSync, shiftReg[7:1]};
  end

endmodule

// ==== uartTb.sv ====
// UART subsystem testbench
`timescale 1ns/100ps
`include "uart_consts.svh"

module uartTb;
  import uartBusPkg::*;
  import uartLinePkg::*;

  localparam busAddr_t rbrAddr = 3'd0;
  localparam busAddr_t ierAddr = 3'd1;
  localparam busAddr_t iirAddr = 3'd2;
  localparam busAddr_t lcrAddr = 3'd3;
  localparam busAddr_t lsrAddr = 3'd5;
  localparam busAddr_t scrAddr = 3'd7;
  localparam int laneCount = `UART_XLEN / 8;
  localparam int maxDivisor = 4;
  // About 11 frames are on the line in all tests, so 12 at the slowest divisor is enough
  localparam int cycleLimit = 12 * 10 * `UART_OVERSAMPLE * maxDivisor + 2000;

  logic HCLK;
  logic rstN;
  logic HSELUART;
  busAddr_t HADDR;
  logic HWRITE;
  busWord_t HWDATA;
  busWord_t HREADUART;
  logic SIN;
  logic SOUT;
  logic INTR;
  logic TXRDYb;
  logic RXRDYb;
  logic bitBang;
  logic bangLevel;
  integer seed;
  int cycleCount;
  int errorCount;
  int testErrors;
  int testCount;
  int failedTests;
  divisor_t divisor;
  uartByte_t rxModel[$];

  uartTop i_uartTop (.HCLK, .rstN, .HSELUART, .HADDR, .HWRITE, .HWDATA, .HREADUART,
                     .SIN, .SOUT, .INTR, .TXRDYb, .RXRDYb);

  // The line loops back unless a hand-made frame is being driven
  assign SIN = bitBang ? bangLevel : SOUT;

  initial begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK;
  end

  ////////////////////////////////////////
  // Checks and bus access
  ////////////////////////////////////////

  task automatic checkByte(input uartByte_t actual, input uartByte_t expected,
                           input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s is %02h, expected %02h", $time, what, actual, expected);
    end
  endtask

  task automatic checkWord(input busWord_t actual, input busWord_t expected, input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s is %08h, expected %08h", $time, what, actual, expected);
    end
  endtask

  task automatic checkBit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  function automatic uartByte_t randomByte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Address phase on one falling edge, data phase on the next
  // Lanes other than the addressed one carry junk the bridge must ignore
  task automatic busWrite(input busAddr_t addr, input uartByte_t data);
    busWord_t word;
    word = $random(seed);
    word[8 * (addr % laneCount) +: 8] = data;
    @(negedge HCLK);
    HSELUART = 1'b1;
    HWRITE = 1'b1;
    HADDR = addr;
    @(negedge HCLK);
    HSELUART = 1'b0;
    HWDATA = word;
  endtask

  // Read data is sampled mid data phase, before an RBR pop at its end
  task automatic busRead(input busAddr_t addr, output busWord_t word);
    @(negedge HCLK);
    HSELUART = 1'b1;
    HWRITE = 1'b0;
    HADDR = addr;
    @(negedge HCLK);
    HSELUART = 1'b0;
    word = HREADUART;
  endtask

  task automatic readCheck(input busAddr_t addr, input uartByte_t expected, input string what);
    busWord_t word;
    busRead(addr, word);
    checkWord(word, {laneCount{expected}}, what);
  endtask

  // Polls LSR until one of the mask bits is set
  task automatic waitLsr(input uartByte_t mask, output uartByte_t lsr);
    busWord_t word;
    lsr = '0;
    while ((lsr & mask) == '0) begin
      busRead(lsrAddr, word);
      lsr = word[7:0];
    end
  endtask

  // One bit on the line lasts 16 baud ticks of divisor clocks each
  task automatic sendBit(input logic level);
    bangLevel = level;
    repeat (`UART_OVERSAMPLE * divisor) @(negedge HCLK);
  endtask

  task automatic sendFrame(input uartByte_t data, input logic stopLevel);
    @(negedge HCLK);
    bitBang = 1'b1;
    sendBit(1'b0);
    for (int i = 0; i < 8; i++) sendBit(data[i]);
    sendBit(stopLevel);
    bangLevel = 1'b1;
    bitBang = 1'b0;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errorCount == testErrors) begin
      $display("test %0d %s: ok", testCount, name);
    end else begin
      failedTests++;
      $display("test %0d %s: %0d checks wrong", testCount, name, errorCount - testErrors);
    end
    testErrors = errorCount;
  endtask

  ////////////////////////////////////////
  // Run limit
  ////////////////////////////////////////

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", cycleLimit);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    uartByte_t data;
    uartByte_t lsr;
    uartByte_t scrVal;
    uartByte_t lcrVal;
    uartByte_t dlmVal;
    seed = 32'h598a;
    rstN = 1'b0;
    HSELUART = 1'b0;
    HWRITE = 1'b0;
    HADDR = '0;
    HWDATA = '0;
    bitBang = 1'b0;
    bangLevel = 1'b1;
    divisor = divisor_t'(1);
    errorCount = 0;
    testErrors = 0;
    testCount = 0;
    failedTests = 0;
    repeat (2) @(negedge HCLK);
    rstN = 1'b1;

    // THRE and TEMT set, nothing received, no interrupt source enabled
    @(negedge HCLK);
    checkBit(INTR, 1'b0, "INTR after reset");
    checkBit(TXRDYb, 1'b0, "TXRDYb after reset");
    checkBit(RXRDYb, 1'b1, "RXRDYb after reset");
    checkBit(SOUT, 1'b1, "SOUT after reset");
    readCheck(lsrAddr, 8'h60, "LSR after reset");
    readCheck(iirAddr, 8'h01, "IIR after reset");
    finishTest("reset values");

    scrVal = randomByte();
    busWrite(scrAddr, scrVal);
    readCheck(scrAddr, scrVal, "SCR");
    // DLAB stays clear here and gets its own check below
    lcrVal = randomByte() & 8'h7f;
    busWrite(lcrAddr, lcrVal);
    readCheck(lcrAddr, lcrVal, "LCR");
    dlmVal = randomByte();
    divisor = divisor_t'(1 + randomByte() % maxDivisor);
    busWrite(lcrAddr, 8'h80);
    busWrite(rbrAddr, divisor[7:0]);
    busWrite(ierAddr, dlmVal);
    readCheck(rbrAddr, divisor[7:0], "DLL");
    readCheck(ierAddr, dlmVal, "DLM");
    busWrite(ierAddr, 8'h00);
    readCheck(ierAddr, 8'h00, "DLM cleared");
    // Address 1 is IER again once DLAB drops, and must not touch DLM
    busWrite(lcrAddr, 8'h03);
    busWrite(ierAddr, 8'h03);
    readCheck(ierAddr, 8'h03, "IER");
    busWrite(lcrAddr, 8'h83);
    readCheck(rbrAddr, divisor[7:0], "DLL after IER write");
    readCheck(ierAddr, 8'h00, "DLM after IER write");
    readCheck(lcrAddr, 8'h83, "LCR with DLAB");
    busWrite(lcrAddr, 8'h03);
    busWrite(ierAddr, 8'h00);
    readCheck(ierAddr, 8'h00, "IER cleared");
    finishTest("register access");

    rxModel.delete();
    repeat (4) begin
      data = randomByte();
      rxModel.push_back(data);
      busWrite(rbrAddr, data);
    end
    while (rxModel.size() > 0) begin
      waitLsr(8'h01, lsr);
      data = rxModel.pop_front();
      readCheck(rbrAddr, data, "RBR loopback byte");
    end
    waitLsr(8'h40, lsr);
    readCheck(lsrAddr, 8'h60, "LSR after loopback");
    finishTest("loopback");

    // Four bytes fill the receive FIFO, the fifth one is lost
    repeat (4) begin
      data = randomByte();
      rxModel.push_back(data);
      busWrite(rbrAddr, data);
    end
    waitLsr(8'h40, lsr);
    busWrite(rbrAddr, randomByte());
    // Polling LSR here would clear overrun, so wait out one frame and two more bit times
    repeat (12 * `UART_OVERSAMPLE * divisor) @(negedge HCLK);
    readCheck(lsrAddr, 8'h63, "LSR with overrun");
    checkBit(RXRDYb, 1'b0, "RXRDYb with bytes waiting");
    while (rxModel.size() > 0) begin
      data = rxModel.pop_front();
      readCheck(rbrAddr, data, "RBR byte before overrun");
    end
    readCheck(lsrAddr, 8'h60, "LSR after overrun read");
    checkBit(RXRDYb, 1'b1, "RXRDYb after all bytes read");
    finishTest("overrun");

    data = randomByte();
    sendFrame(data, 1'b0);
    waitLsr(8'h01, lsr);
    checkByte(lsr, 8'h69, "LSR with framing error");
    readCheck(rbrAddr, data, "RBR with framing error");
    finishTest("framing error");

    busWrite(ierAddr, 8'h02);
    @(negedge HCLK);
    checkBit(INTR, 1'b1, "INTR on transmit empty");
    readCheck(iirAddr, 8'h02, "IIR transmit empty");
    busWrite(ierAddr, 8'h03);
    data = randomByte();
    busWrite(rbrAddr, data);
    waitLsr(8'h01, lsr);
    // Received data outranks transmit empty
    readCheck(iirAddr, 8'h04, "IIR receive data");
    checkBit(INTR, 1'b1, "INTR on receive data");
    readCheck(rbrAddr, data, "RBR interrupt byte");
    readCheck(iirAddr, 8'h02, "IIR after RBR read");
    busWrite(ierAddr, 8'h00);
    @(negedge HCLK);
    checkBit(INTR, 1'b0, "INTR disabled");
    finishTest("interrupts");

    $display("Summary: %0d tests, %0d tests failed, %0d checks wrong",
             testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== uartTb_sva.sv ====
// UART bus and line assertions
`timescale 1ns/100ps
`include "uart_consts.svh"

module uartTbSva (
  input logic                 HCLK,
  input logic                 rstN,
  input logic                 HSELUART,
  input logic                 HWRITE,
  input uartBusPkg::busWord_t HREADUART,
  input logic                 SOUT,
  input logic                 INTR,
  input logic [1:0]           ier
);

  localparam int laneCount = `UART_XLEN / 8;

  // In the data phase of a read every lane carries the same register byte
  lanesEqualA: assert property (@(posedge HCLK) disable iff (!rstN)
    (HSELUART && !HWRITE) |=> (HREADUART == {laneCount{HREADUART[7:0]}}))
    else $error("Read data differs between byte lanes");

  // With no source enabled the interrupt pin must stay quiet
  intrQuietA: assert property (@(posedge HCLK) disable iff (!rstN)
    (ier == 2'b00) |-> !INTR)
    else $error("INTR high while IER is zero");

  // Idle line and no interrupt right after reset is released
  resetIdleA: assert property (@(posedge HCLK)
    $rose(rstN) |-> (SOUT && !INTR))
    else $error("SOUT or INTR wrong after reset");

endmodule

// Checker sits inside every uartTop and looks at the core's IER bits
bind uartTop uartTbSva i_uartTbSva (.HCLK, .rstN, .HSELUART, .HWRITE, .HREADUART,
                                    .SOUT, .INTR, .ier(i_uartCore.ier));

// ==== uartTop.sv ====
// UART top level
`timescale 1ns/100ps

module uartTop (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  logic                 HSELUART,
  input  uartBusPkg::busAddr_t HADDR,
  input  logic                 HWRITE,
  input  uartBusPkg::busWord_t HWDATA,
  output uartBusPkg::busWord_t HREADUART,
  input  logic                 SIN,
  output logic                 SOUT,
  output logic                 INTR,
  output logic                 TXRDYb,
  output logic                 RXRDYb
);

  // Byte-wide register accesses between the bus side and the core
  uartRegIf regs ();

  // Address and data phases become register strobes here
  uartBusBridge i_uartBusBridge (
    .HCLK,
    .rstN,
    .HSELUART,
    .HWRITE,
    .HADDR,
    .HWDATA,
    .HREADUART,
    .regs(regs.bridge)
  );

  // Registers, FIFOs and the serial line
  uartCore i_uartCore (
    .HCLK,
    .rstN,
    .regs(regs.core),
    .SIN,
    .SOUT,
    .INTR,
    .TXRDYb,
    .RXRDYb
  );

endmodule

// ==== uartTx.sv ====
// UART 8N1 transmitter
`timescale 1ns/100ps
`include "uart_consts.svh"

module uartTx (
  input  logic                   HCLK,
  input  logic                   rstN,
  input  logic                   tick,
  input  logic                   dataValid,
  input  uartLinePkg::uartByte_t data,
  output logic                   take,
  output logic                   idle,
  output logic                   SOUT
);
  import uartLinePkg::*;

  localparam tickCount_t lastTick = tickCount_t'(`UART_OVERSAMPLE - 1);

  txState_e state;
  tickCount_t tickCnt;
  bitIndex_t bitIdx;
  uartByte_t shiftReg;
  logic bitDone;

  // A byte is accepted in the one idle cycle where the FIFO has something
  assign idle = (state == stTxIdle);
  assign take = idle && dataValid;

  // Last tick of the current bit period
  assign bitDone = tick && (tickCnt == lastTick);

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      state <= stTxIdle;
      tickCnt <= '0;
      bitIdx <= '0;
    end else if (idle) begin
      tickCnt <= '0;
      if (take) state <= stTxStart;
    end else if (tick) begin
      tickCnt <= bitDone ? '0 : tickCnt + 1'b1;
      if (bitDone) begin
        case (state)
          stTxStart: begin
            state <= stTxData;
            bitIdx <= '0;
          end
          stTxData: begin
            if (bitIdx == '1) state <= stTxStop;
            bitIdx <= bitIdx + 1'b1;
          end
          default: state <= stTxIdle;
        endcase
      end
    end
  end

  // Data leaves LSB first
  always_ff @(posedge HCLK) begin
    if (take) shiftReg <= data;
    else if ((state == stTxData) && bitDone) shiftReg <= shiftReg >> 1;
  end

  // Line idles high, start bit low, stop bit high
  always_comb begin
    case (state)
      stTxStart: SOUT = 1'b0;
      stTxData: SOUT = shiftReg[0];
      default: SOUT = 1'b1;
    endcase
  end

endmodule

// ==== uart_consts.svh ====
// UART build constants
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

////////////////////////////////////////
// Bus side
////////////////////////////////////////

// Width of the system bus data word in bits
`define UART_XLEN 32

////////////////////////////////////////
// Serial side
////////////////////////////////////////

// Number of bytes held by each of the transmit and receive FIFOs
`define UART_FIFO_DEPTH 4

// Baud ticks per serial bit, as in the 16550 16x clock
`define UART_OVERSAMPLE 16

`endif
